// File: hw/branch_settings.svh
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// reservation station depth, 2 or more
`define RS_ENTRIES 4

// reorder buffer tag width
`define ROB_TAG_W 4

// data and address width
`define XLEN 32

`endif

// File: hw/cdbPkg.sv
`default_nettype none

`include "branch_settings.svh"

package cdbPkg;

    typedef logic [`ROB_TAG_W-1:0] robTag_t;

    // one broadcast on a common data bus
    typedef struct packed {
        logic             valid;
        robTag_t          tag;
        logic [`XLEN-1:0] data;
    } cdbWrite_t;

endpackage

`default_nettype wire

// File: hw/branchPkg.sv
`default_nettype none

`include "branch_settings.svh"

package branchPkg;

    import cdbPkg::*;

    // funct3 codes for conditional branches, jumps fill the gap
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        JAL  = 3'd2,
        JALR = 3'd3,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } branchOp_e;

    // source operand, either a value or a pending tag
    typedef struct packed {
        logic [`XLEN-1:0] value;
        robTag_t          tag;
        logic             ready;
    } operand_t;

    typedef struct packed {
        branchOp_e        op;
        operand_t         src1;
        operand_t         src2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] offset;
        robTag_t          dest;
    } issueReq_t;

    typedef struct packed {
        branchOp_e        op;
        logic [`XLEN-1:0] src1;
        logic [`XLEN-1:0] src2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] offset;
        robTag_t          dest;
    } branchReq_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        robTag_t          dest;
        logic [`XLEN-1:0] link;
        redirect_t        redirect;
    } branchResult_t;

endpackage

`default_nettype wire

// File: hw/branchRs.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module branchRs (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  rollback,
    input  logic                  issueValid,
    input  branchPkg::issueReq_t  issue,
    output logic                  issueReady,
    input  cdbPkg::cdbWrite_t     aluCdb,
    input  cdbPkg::cdbWrite_t     lsqCdb,
    output logic                  dispatchValid,
    output branchPkg::branchReq_t dispatch,
    input  logic                  dispatchReady
);

    import cdbPkg::*;
    import branchPkg::*;

    localparam int IDX_W = $clog2(`RS_ENTRIES);

    typedef struct packed {
        branchOp_e        op;
        operand_t         src1;
        operand_t         src2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] offset;
        robTag_t          dest;
    } rsEntry_t;

    logic [`RS_ENTRIES-1:0] busy;
    rsEntry_t               entries [`RS_ENTRIES];
    rsEntry_t               newEntry;
    rsEntry_t               selEntry;

    logic [IDX_W-1:0] freeIdx;
    logic [IDX_W-1:0] readyIdx;
    logic             anyFree;
    logic             anyReady;
    logic             issueFire;
    logic             dispatchFire;

    // snoop both buses, lsq wins when both carry the tag
    function automatic operand_t capture(operand_t opnd, cdbWrite_t alu, cdbWrite_t lsq);
        operand_t res;
        res = opnd;
        if (!opnd.ready) begin
            if (lsq.valid && lsq.tag == opnd.tag) begin
                res.value = lsq.data;
                res.ready = 1'b1;
            end else if (alu.valid && alu.tag == opnd.tag) begin
                res.value = alu.data;
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    // lowest free entry
    always_comb begin
        freeIdx = '0;
        anyFree = 1'b0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeIdx = IDX_W'(i);
                anyFree = 1'b1;
            end
        end
    end

    // lowest busy entry with both operands in hand
    always_comb begin
        readyIdx = '0;
        anyReady = 1'b0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (busy[i] && entries[i].src1.ready && entries[i].src2.ready) begin
                readyIdx = IDX_W'(i);
                anyReady = 1'b1;
            end
        end
    end

    assign issueReady    = anyFree;
    assign issueFire     = issueValid && issueReady;
    assign dispatchValid = anyReady;
    assign dispatchFire  = dispatchValid && dispatchReady;

    // issue-time bypass so a broadcast on the issue edge is not lost
    always_comb begin
        newEntry.op     = issue.op;
        newEntry.src1   = capture(issue.src1, aluCdb, lsqCdb);
        newEntry.src2   = capture(issue.src2, aluCdb, lsqCdb);
        newEntry.pc     = issue.pc;
        newEntry.offset = issue.offset;
        newEntry.dest   = issue.dest;
    end

    assign selEntry = entries[readyIdx];

    always_comb begin
        dispatch.op     = selEntry.op;
        dispatch.src1   = selEntry.src1.value;
        dispatch.src2   = selEntry.src2.value;
        dispatch.pc     = selEntry.pc;
        dispatch.offset = selEntry.offset;
        dispatch.dest   = selEntry.dest;
    end

    // rollback beats issue and dispatch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= '0;
        end else if (rollback) begin
            busy <= '0;
        end else begin
            if (issueFire) begin
                busy[freeIdx] <= 1'b1;
            end
            if (dispatchFire) begin
                busy[readyIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (issueFire && freeIdx == IDX_W'(i)) begin
                entries[i] <= newEntry;
            end else begin
                entries[i].src1 <= capture(entries[i].src1, aluCdb, lsqCdb);
                entries[i].src2 <= capture(entries[i].src2, aluCdb, lsqCdb);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/branchUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module branchUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     rollback,
    input  logic                     dispatchValid,
    input  branchPkg::branchReq_t    dispatch,
    output logic                     dispatchReady,
    output logic                     resultValid,
    output branchPkg::branchResult_t result,
    input  logic                     resultReady
);

    import branchPkg::*;

    logic             taken;
    logic             isJump;
    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] jumpTarget;
    logic             dispatchFire;
    branchResult_t    nextResult;

    // condition evaluation
    always_comb begin
        case (dispatch.op)
            BEQ:     taken = dispatch.src1 == dispatch.src2;
            BNE:     taken = dispatch.src1 != dispatch.src2;
            BLT:     taken = $signed(dispatch.src1) < $signed(dispatch.src2);
            BGE:     taken = $signed(dispatch.src1) >= $signed(dispatch.src2);
            BLTU:    taken = dispatch.src1 < dispatch.src2;
            BGEU:    taken = dispatch.src1 >= dispatch.src2;
            default: taken = 1'b1;
        endcase
    end

    assign isJump = (dispatch.op == JAL) || (dispatch.op == JALR);
    assign seqPc  = dispatch.pc + `XLEN'd4;

    // jalr target is register based, lsb cleared
    always_comb begin
        if (dispatch.op == JALR) begin
            jumpTarget = (dispatch.src1 + dispatch.offset) & ~`XLEN'd1;
        end else begin
            jumpTarget = dispatch.pc + dispatch.offset;
        end
    end

    always_comb begin
        nextResult.dest            = dispatch.dest;
        nextResult.link            = isJump ? seqPc : '0;
        nextResult.redirect.taken  = taken;
        nextResult.redirect.target = taken ? jumpTarget : seqPc;
    end

    // accept when empty or draining this cycle
    assign dispatchReady = !resultValid || resultReady;
    assign dispatchFire  = dispatchValid && dispatchReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else if (rollback) begin
            resultValid <= 1'b0;
        end else if (dispatchFire) begin
            resultValid <= 1'b1;
        end else if (resultReady) begin
            resultValid <= 1'b0;
        end
    end

    // only loads on a transfer, so held stable under back-pressure
    always_ff @(posedge clk) begin
        if (dispatchFire) begin
            result <= nextResult;
        end
    end

endmodule

`default_nettype wire

// File: hw/branchCluster.sv
`timescale 1ns/1ns
`default_nettype none

module branchCluster (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     rollback,
    input  logic                     issueValid,
    input  branchPkg::issueReq_t     issue,
    output logic                     issueReady,
    input  cdbPkg::cdbWrite_t        aluCdb,
    input  cdbPkg::cdbWrite_t        lsqCdb,
    output logic                     resultValid,
    output branchPkg::branchResult_t result,
    input  logic                     resultReady
);

    import branchPkg::*;

    // dispatch channel
    logic       dispatchValid;
    logic       dispatchReady;
    branchReq_t dispatch;

    branchRs rs_i (
        .clk           (clk),
        .rstN          (rstN),
        .rollback      (rollback),
        .issueValid    (issueValid),
        .issue         (issue),
        .issueReady    (issueReady),
        .aluCdb        (aluCdb),
        .lsqCdb        (lsqCdb),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchReady (dispatchReady)
    );

    branchUnit unit_i (
        .clk           (clk),
        .rstN          (rstN),
        .rollback      (rollback),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchReady (dispatchReady),
        .resultValid   (resultValid),
        .result        (result),
        .resultReady   (resultReady)
    );

endmodule

`default_nettype wire

// File: verification/clkGen.sv
`timescale 1ns/1ns
`default_nettype none

module clkGen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release just after a rising edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/branchClusterTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module branchClusterTb;

    import cdbPkg::*;
    import branchPkg::*;

    localparam int TAGS    = 1 << `ROB_TAG_W;
    localparam int W_RESET = 0;
    localparam int W_ISSUE = 1;
    localparam int W_TAG   = 2;
    localparam int W_ALL   = 3;
    localparam int W_VALID = 4;

    // one case with its issue, optional broadcast and expected outcome
    typedef struct {
        string         name;
        issueReq_t     req;
        logic          onLsq;
        robTag_t       bTag;
        logic [31:0]   bData;
        int            bDelay;
        branchResult_t expResult;
    } stimRow_t;

    logic            clk;
    logic            rstN;
    logic            rollback;
    logic            issueValid;
    issueReq_t       issue;
    logic            issueReady;
    cdbWrite_t       aluCdb;
    cdbWrite_t       lsqCdb;
    logic            resultValid;
    branchResult_t   result;
    logic            resultReady;

    stimRow_t        stimTable [$];
    branchResult_t   expByTag [TAGS];
    string           nameByTag [TAGS];
    logic [TAGS-1:0] pending;
    logic [TAGS-1:0] waiting;
    int              errors;
    int              timeouts;
    integer          seed;

    clkGen #(.PERIOD(8), .RESET_CYCLES(16)) clk_i (.clk(clk), .rstN(rstN));

    branchCluster dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .rollback    (rollback),
        .issueValid  (issueValid),
        .issue       (issue),
        .issueReady  (issueReady),
        .aluCdb      (aluCdb),
        .lsqCdb      (lsqCdb),
        .resultValid (resultValid),
        .result      (result),
        .resultReady (resultReady)
    );

    // reference model of the branch rules
    function automatic branchResult_t predict(stimRow_t row);
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   seq;
        logic [31:0]   sum;
        branchResult_t res;
        a = (!row.req.src1.ready && row.req.src1.tag == row.bTag) ? row.bData : row.req.src1.value;
        b = (!row.req.src2.ready && row.req.src2.tag == row.bTag) ? row.bData : row.req.src2.value;
        seq = row.req.pc + 32'd4;
        sum = a + row.req.offset;
        case (row.req.op)
            BEQ:     res.redirect.taken = (a == b);
            BNE:     res.redirect.taken = (a != b);
            BLT:     res.redirect.taken = ($signed(a) < $signed(b));
            BGE:     res.redirect.taken = !($signed(a) < $signed(b));
            BLTU:    res.redirect.taken = (a < b);
            BGEU:    res.redirect.taken = !(a < b);
            default: res.redirect.taken = 1'b1;
        endcase
        res.dest = row.req.dest;
        res.link = (row.req.op inside {JAL, JALR}) ? seq : 32'd0;
        res.redirect.target = (row.req.op == JALR) ? {sum[31:1], 1'b0} : row.req.pc + row.req.offset;
        res.redirect.target = res.redirect.taken ? res.redirect.target : seq;
        return res;
    endfunction

    function automatic stimRow_t makeRow(string name, branchOp_e op, logic [31:0] a,
                                         logic [31:0] b, logic [31:0] pc, logic [31:0] off);
        stimRow_t row;
        row.name = name;
        row.req.op = op;
        row.req.src1 = {a, robTag_t'(0), 1'b1};
        row.req.src2 = {b, robTag_t'(0), 1'b1};
        row.req.pc = pc;
        row.req.offset = off;
        row.req.dest = '0;
        row.onLsq = 1'b0;
        row.bTag = '0;
        row.bData = '0;
        row.bDelay = -1;
        return row;
    endfunction

    // one operand waits on a tag and carries a junk value
    function automatic stimRow_t pendOn(stimRow_t row, int which, robTag_t tag,
                                        logic [31:0] data, logic onLsq, int delay);
        if (which == 1) begin
            row.req.src1 = {32'hdead_beef, tag, 1'b0};
        end else begin
            row.req.src2 = {32'hdead_beef, tag, 1'b0};
        end
        row.bTag = tag;
        row.bData = data;
        row.onLsq = onLsq;
        row.bDelay = delay;
        return row;
    endfunction

    function automatic stimRow_t withDest(stimRow_t row, int dest);
        row.req.dest = robTag_t'(dest);
        row.expResult = predict(row);
        return row;
    endfunction

    task automatic addRow(stimRow_t row);
        stimTable.push_back(withDest(row, stimTable.size()));
    endtask

    task automatic buildTable();
        branchOp_e   condOps [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        int          k;
        addRow(makeRow("beq equal", BEQ, 32'h1234, 32'h1234, 32'h100, 32'h20));
        addRow(makeRow("bne equal", BNE, 32'h5, 32'h5, 32'h100, 32'h20));
        addRow(makeRow("blt min vs one", BLT, 32'h8000_0000, 32'h1, 32'h200, 32'hffff_fff0));
        addRow(makeRow("bltu min vs one", BLTU, 32'h8000_0000, 32'h1, 32'h200, 32'hffff_fff0));
        addRow(makeRow("bge minus one vs zero", BGE, 32'hffff_ffff, 32'h0, 32'h300, 32'h8));
        addRow(makeRow("bgeu minus one vs zero", BGEU, 32'hffff_ffff, 32'h0, 32'h300, 32'h8));
        addRow(makeRow("bge equal max", BGE, 32'h7fff_ffff, 32'h7fff_ffff, 32'h300, 32'h8));
        addRow(makeRow("jal back", JAL, 32'h0, 32'h0, 32'h400, 32'hffff_fff8));
        addRow(makeRow("jalr odd sum", JALR, 32'h1000_0003, 32'h0, 32'h500, 32'h10));
        for (int i = 0; i < 6; i++) begin
            k = $unsigned($random(seed)) % 6;
            a = $random(seed);
            b = (i % 3 == 0) ? a : $random(seed);
            pc = $random(seed) & 32'hffff_fffc;
            addRow(makeRow($sformatf("random %0d", i), condOps[k], a, b, pc, 32'h1c));
        end
        addRow(pendOn(makeRow("wait alu", BEQ, 0, 32'h55, 32'h600, 32'h40), 1, 5, 32'h55, 0, 3));
        addRow(pendOn(makeRow("wait lsq", BLTU, 32'h200, 0, 32'h700, 32'h40),
                      2, 9, 32'h100, 1, 5));
        addRow(pendOn(makeRow("issue edge bypass", BNE, 0, 32'h55, 32'h800, 32'h40),
                      1, 7, 32'h55, 0, 0));
        addRow(pendOn(makeRow("jalr wait lsq", JALR, 0, 0, 32'h900, 32'h4), 1, 3, 32'h2001, 1, 2));
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic condMet(int kind, robTag_t tag);
        case (kind)
            W_RESET: return rstN === 1'b1;
            W_ISSUE: return issueReady;
            W_TAG:   return !pending[tag];
            W_ALL:   return pending == '0;
            default: return resultValid;
        endcase
    endfunction

    task automatic waitUntil(int kind, robTag_t tag, string what);
        int cycles;
        cycles = 0;
        while (!condMet(kind, tag) && cycles < 200) begin
            step();
            cycles++;
        end
        if (!condMet(kind, tag)) begin
            timeouts++;
            $display("timeout after 200 cycles waiting for %s", what);
        end
    endtask

    task automatic driveBus(logic onLsq, robTag_t tag, logic [31:0] data);
        if (onLsq) begin
            lsqCdb = {1'b1, tag, data};
        end else begin
            aluCdb = {1'b1, tag, data};
        end
    endtask

    task automatic releaseTag(logic onLsq, robTag_t tag, logic [31:0] data, robTag_t dest);
        waiting[dest] = 1'b0;
        driveBus(onLsq, tag, data);
        step();
        aluCdb = '0;
        lsqCdb = '0;
    endtask

    task automatic applyRow(stimRow_t row);
        waitUntil(W_ISSUE, 0, {"issueReady for ", row.name});
        expByTag[row.req.dest] = row.expResult;
        nameByTag[row.req.dest] = row.name;
        pending[row.req.dest] = 1'b1;
        waiting[row.req.dest] = !(row.req.src1.ready && row.req.src2.ready);
        issueValid = 1'b1;
        issue = row.req;
        // delay zero puts the broadcast on the issue edge
        if (row.bDelay == 0) begin
            waiting[row.req.dest] = 1'b0;
            driveBus(row.onLsq, row.bTag, row.bData);
        end
        step();
        issueValid = 1'b0;
        aluCdb = '0;
        lsqCdb = '0;
        if (row.bDelay > 0) begin
            repeat (row.bDelay - 1) step();
            releaseTag(row.onLsq, row.bTag, row.bData, row.req.dest);
        end
    endtask

    task automatic checkResult(string name, branchResult_t exp, branchResult_t act);
        if (act.dest !== exp.dest || act.link !== exp.link) begin
            errors++;
            $display("CHECK FAILED %s: expected tag %0d link %h, actual tag %0d link %h",
                     name, exp.dest, exp.link, act.dest, act.link);
        end
    endtask

    task automatic checkRedirect(string name, redirect_t exp, redirect_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected taken %b target %h, actual taken %b target %h",
                     name, exp.taken, exp.target, act.taken, act.target);
        end
    endtask

    task automatic checkFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // scoreboard sampling each transfer ahead of its rising edge
    always @(negedge clk) begin
        if (rstN && resultValid && resultReady) begin
            if (!pending[result.dest]) begin
                errors++;
                $display("result for tag %0d was not expected", result.dest);
            end else begin
                if (waiting[result.dest]) begin
                    errors++;
                    $display("result for tag %0d came before its operand", result.dest);
                end
                checkResult(nameByTag[result.dest], expByTag[result.dest], result);
                checkRedirect(nameByTag[result.dest], expByTag[result.dest].redirect,
                              result.redirect);
                pending[result.dest] = 1'b0;
            end
        end
    end

    initial begin
        stimRow_t      row;
        branchResult_t held;
        seed = 32'hf8c1_48e8;
        errors = 0;
        timeouts = 0;
        pending = '0;
        waiting = '0;
        rollback = 1'b0;
        issueValid = 1'b0;
        issue = '0;
        aluCdb = '0;
        lsqCdb = '0;
        resultReady = 1'b1;
        buildTable();
        waitUntil(W_RESET, 0, "reset release");
        step();
        checkFlag("issueReady after reset", 1'b1, issueReady);
        checkFlag("resultValid after reset", 1'b0, resultValid);

        foreach (stimTable[i]) begin
            applyRow(stimTable[i]);
            waitUntil(W_TAG, stimTable[i].req.dest, stimTable[i].name);
        end

        // result must hold under back-pressure while the rest stays queued
        resultReady = 1'b0;
        for (int i = 0; i < 3; i++) begin
            row = makeRow($sformatf("held %0d", i), BLTU, i, 1, 32'ha00, 32'h8);
            applyRow(withDest(row, 10 + i));
        end
        waitUntil(W_VALID, 0, "first held result");
        held = result;
        repeat (10) begin
            step();
            checkResult("held result stable", held, result);
            checkRedirect("held result stable", held.redirect, result.redirect);
        end
        resultReady = 1'b1;
        waitUntil(W_ALL, 0, "queued results after release");

        // fill the station, free one entry, refill, then roll back
        for (int i = 0; i <= `RS_ENTRIES; i++) begin
            row = pendOn(makeRow($sformatf("full %0d", i), BEQ, 0, 32'h7, 32'hb00, 32'h40),
                         1, robTag_t'(8 + i), 32'h7, 1'b0, -1);
            applyRow(withDest(row, i));
            if (i == `RS_ENTRIES - 1) begin
                checkFlag("issueReady with station full", 1'b0, issueReady);
                releaseTag(1'b0, robTag_t'(8), 32'h7, robTag_t'(0));
                waitUntil(W_TAG, 0, "result of released entry");
                checkFlag("issueReady after release", 1'b1, issueReady);
            end
        end
        checkFlag("issueReady after refill", 1'b0, issueReady);
        rollback = 1'b1;
        step();
        rollback = 1'b0;
        pending = '0;
        waiting = '0;
        checkFlag("issueReady after rollback", 1'b1, issueReady);
        for (int i = 1; i <= `RS_ENTRIES; i++) begin
            releaseTag(1'b1, robTag_t'(8 + i), 32'h7, robTag_t'(i));
        end
        repeat (20) step();

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/cdbPkg.sv
hw/branchPkg.sv
hw/branchRs.sv
hw/branchUnit.sv
hw/branchCluster.sv
verification/clkGen.sv
verification/branchClusterTb.sv

// File: Bender.yml
package:
  name: branch_cluster

sources:
  - include_dirs:
      - hw
    files:
      - hw/cdbPkg.sv
      - hw/branchPkg.sv
      - hw/branchRs.sv
      - hw/branchUnit.sv
      - hw/branchCluster.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/clkGen.sv
      - verification/branchClusterTb.sv
